// ==== tbWbSim.sv ====
/*
 * Testbench for the two-master Wishbone peripheral subsystem.
 * Accesses come from wbSimCases.txt, one per line. Lines starting with # are skipped.
 * A run of lines flagged concurrent is shared out to both masters at once.
 * Ack latency is checked only for accesses that run alone on the bus.
 * The first mismatch ends the run.
 */
`timescale 1ns/10ps
`default_nettype none

module tbWbSim
   import wbSimPkg::*;
   ();

   localparam int NUM_M      = 2;
   localparam int CLK_PERIOD = 100;  // ns
   localparam int MAX_CASES  = 64;

   logic                        CLK_I, rstN;
   logic [NUM_M-1:0]            mCyc, mStb, mWe, mAck, mErr;
   logic [NUM_M-1:0][ADR_W-1:0] mAdr;
   logic [NUM_M-1:0][DAT_W-1:0] mDatW;
   logic [NUM_M-1:0][SEL_W-1:0] mSel;
   logic [DAT_W-1:0]            mDatR;

   // Case table filled from the file
   int               numCases = 0;
   int               cMaster [MAX_CASES];
   bit               cConc   [MAX_CASES];
   bit               cWe     [MAX_CASES];
   bit               cExpErr [MAX_CASES];
   logic [ADR_W-1:0] cAdr    [MAX_CASES];
   logic [DAT_W-1:0] cDatW   [MAX_CASES];
   logic [SEL_W-1:0] cSel    [MAX_CASES];
   logic [DAT_W-1:0] cExpDat [MAX_CASES];

   logic [DAT_W-1:0] cfgModel;             // Expected config register contents
   int               errCount     = 0;
   int               lastWho      = 0;     // Master served last
   bit               otherPending = 1'b0;  // Other master waited at that response

   wbSimTop #(.NUM_MASTERS(NUM_M), .RESET_LAT(1)) UUT (
      .CLK_I(CLK_I), .rstN(rstN), .mCyc(mCyc), .mStb(mStb), .mWe(mWe),
      .mAdr(mAdr), .mDatW(mDatW), .mSel(mSel), .mAck(mAck), .mErr(mErr), .mDatR(mDatR)
   );

   initial begin
      CLK_I = 1'b0;
      forever #(CLK_PERIOD / 2) CLK_I = ~CLK_I;
   end

   task automatic checkEqual(input string sigName, input logic [31:0] expVal,
                             input logic [31:0] actVal);
      if (expVal !== actVal) begin
         errCount++;
         $display("FAILED at %0t: %s expected %h actual %h", $time, sigName, expVal, actVal);
         $display("ERRORS FOUND");
         $fatal(1, "Mismatch on %s", sigName);
      end
   endtask

   // Config and error answer in one cycle, latency register in max(field,1)
   function automatic int expectedLat(input bit we, input logic [ADR_W-1:0] adr,
                                      input bit expErr);
      int l;
      if (expErr || adr[CFG_BIT])
         return 1;
      l = we ? int'(cfgModel[WLAT_LSB +: LAT_W]) : int'(cfgModel[RLAT_LSB +: LAT_W]);
      return (l == 0) ? 1 : l;
   endfunction

   // One classic cycle on master m with latency counted from the granted strobe
   task automatic busAccess(input int m, input bit we, input logic [ADR_W-1:0] adr,
                            input logic [DAT_W-1:0] datW, input logic [SEL_W-1:0] sel,
                            output logic [DAT_W-1:0] datR, output bit ack, output bit err,
                            output int lat);
      bit done;
      done = 1'b0;
      lat  = -1;
      @(posedge CLK_I);
      mCyc[m]  <= 1'b1;
      mStb[m]  <= 1'b1;
      mWe[m]   <= we;
      mAdr[m]  <= adr;
      mDatW[m] <= datW;
      mSel[m]  <= sel;
      while (!done) begin
         @(negedge CLK_I);                   // Outputs settled mid-cycle
         if (UUT.sStb && UUT.arbInst.grantIdx == m)
            lat++;
         if (mAck[m] || mErr[m]) begin
            done = 1'b1;
            ack  = mAck[m];
            err  = mErr[m];
            datR = mDatR;
         end
      end
      @(posedge CLK_I);
      mCyc[m] <= 1'b0;                       // Drop in the cycle after the response
      mStb[m] <= 1'b0;
   endtask

   task automatic runCase(input int k);
      logic [DAT_W-1:0] datR;
      bit               ack, err;
      int               lat, expLat, m;
      m      = cMaster[k];
      expLat = expectedLat(cWe[k], cAdr[k], cExpErr[k]);
      busAccess(m, cWe[k], cAdr[k], cDatW[k], cSel[k], datR, ack, err, lat);
      checkEqual($sformatf("mErr[%0d]", m), cExpErr[k], err);
      checkEqual($sformatf("mAck[%0d]", m), !cExpErr[k], ack);
      if (!cWe[k] && !cExpErr[k])
         checkEqual($sformatf("mDatR[%0d]", m), cExpDat[k], datR);
      if (!cConc[k])
         checkEqual($sformatf("ackLatency[%0d]", m), expLat, lat);
      if (cWe[k] && !cExpErr[k] && cAdr[k][CFG_BIT])
         for (int b = 0; b < SEL_W; b++)
            if (cSel[k][b])
               cfgModel[b*BYTE_W +: BYTE_W] = cDatW[k][b*BYTE_W +: BYTE_W];
   endtask

   // Master m takes its own lines of a concurrent run
   task automatic runGroup(input int m, input int first, input int last);
      for (int k = first; k < last; k++) begin
         if (cMaster[k] == m) begin
            repeat ($urandom % 4) @(posedge CLK_I);  // Start skew 0..3
            runCase(k);
         end
      end
   endtask

   task automatic loadCases();
      int               fd, n, code, m, conc, we, err;
      string            line;
      logic [DAT_W-1:0] adr, datW, sel, expDat;
      fd = $fopen("wbSimCases.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the cases file wbSimCases.txt");
         $display("ERRORS FOUND");
         $fatal(1, "No stimulus");
      end else begin
         while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.getc(0) != "#") begin
               n = $sscanf(line, "%d %d %d %h %h %h %h %d",
                           m, conc, we, adr, datW, sel, expDat, err);
               if (n == 8 && numCases < MAX_CASES) begin
                  cMaster[numCases] = m;
                  cConc[numCases]   = conc[0];
                  cWe[numCases]     = we[0];
                  cAdr[numCases]    = adr;
                  cDatW[numCases]   = datW;
                  cSel[numCases]    = sel[SEL_W-1:0];
                  cExpDat[numCases] = expDat;
                  cExpErr[numCases] = err[0];
                  numCases++;
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // Whoever waited at the last response must be served next
   always @(negedge CLK_I) begin : rrMonitor
      int who;
      if (rstN && (mAck | mErr) != '0) begin
         who = (mAck[1] | mErr[1]) ? 1 : 0;
         if (otherPending)
            checkEqual("rrWinner", 1 - lastWho, who);
         lastWho      = who;
         otherPending = mCyc[1 - who] & mStb[1 - who];
      end
   end

   initial begin : watchdog
      wait (numCases > 0);
      #((numCases * (64 + 2) + 4) * CLK_PERIOD);
      $display("Timeout: the bus hung and an access never completed");
      $display("ERRORS FOUND");
      $fatal(1, "Watchdog expired");
   end

   initial begin : mainSeq
      int i, j;
      void'($urandom(32'h7fe7_365e));
      rstN     = 1'b0;
      mCyc     = '0;
      mStb     = '0;
      mWe      = '0;
      mAdr     = '0;
      mDatW    = '0;
      mSel     = '0;
      cfgModel = 32'h0000_0101;  // Both latency fields at 1
      loadCases();
      repeat (4) @(posedge CLK_I);
      rstN <= 1'b1;
      i = 0;
      while (i < numCases) begin
         if (!cConc[i]) begin
            runCase(i);
            i++;
         end else begin
            j = i;
            while (j < numCases && cConc[j])
               j++;
            fork
               runGroup(0, i, j);
               runGroup(1, i, j);
            join
            i = j;
         end
      end
      repeat (2) @(posedge CLK_I);
      if (errCount == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
wbSimPkg.sv
wbArbiter.sv
wbAddrDecode.sv
wbCfgReg.sv
wbLatencyReg.sv
wbSimTop.sv
wbBus_asserts.sv
tbWbSim.sv

// ==== wbAddrDecode.sv ====
/*
 * Address decoder for the two register slaves.
 * Both select bits set goes to the config register.
 * Unmapped accesses get a one-cycle err one cycle after the strobe.
 * Slaves must never ack in the same cycle.
 */
`timescale 1ns/10ps
`default_nettype none

module wbAddrDecode
   import wbSimPkg::*;
   (
   input  logic             CLK_I,
   input  logic             rstN,
   input  logic             sStb,
   input  logic [ADR_W-1:0] sAdr,
   input  logic             cfgAck,
   input  logic             latAck,
   input  logic [DAT_W-1:0] cfgDatR,
   input  logic [DAT_W-1:0] latDatR,
   output logic             cfgStb,
   output logic             latStb,
   output logic             sAck,
   output logic             sErr,
   output logic [DAT_W-1:0] sDatR
   );

   logic inRegion;
   logic cfgHit;
   logic latHit;
   logic errQ;

   assign inRegion = (sAdr & REGION_MASK) == REGION_BASE;
   assign cfgHit   = inRegion & sAdr[CFG_BIT];
   assign latHit   = inRegion & sAdr[LAT_BIT] & ~sAdr[CFG_BIT];  // Config has priority

   assign cfgStb = sStb & cfgHit;
   assign latStb = sStb & latHit;

   // Error pulse for an unmapped strobe
   // Cleared by its own high level or once the strobe drops
   always_ff @(posedge CLK_I) begin
      if (!rstN)
         errQ <= 1'b0;
      else
         errQ <= sStb & ~(cfgHit | latHit) & ~errQ;
   end

   assign sErr  = errQ;
   assign sAck  = cfgAck | latAck;
   assign sDatR = cfgAck ? cfgDatR : latDatR;  // Whoever acks owns the data

endmodule

`default_nettype wire

// ==== wbArbiter.sv ====
/*
 * Round-robin arbiter for Wishbone classic masters.
 * The grant is registered, so the shared strobe lags the master strobe by one cycle.
 * The response is routed back combinationally and the grant drops with it.
 * Masters must hold their request until ack or err. No bursts, no locking.
 */
`timescale 1ns/10ps
`default_nettype none

module wbArbiter
   import wbSimPkg::*;
   #(parameter int NUM_MASTERS = 2)
   (
   input  logic                                 CLK_I,
   input  logic                                 rstN,
   input  logic [NUM_MASTERS-1:0]               mCyc,
   input  logic [NUM_MASTERS-1:0]               mStb,
   input  logic [NUM_MASTERS-1:0]               mWe,
   input  logic [NUM_MASTERS-1:0][ADR_W-1:0]    mAdr,
   input  logic [NUM_MASTERS-1:0][DAT_W-1:0]    mDatW,
   input  logic [NUM_MASTERS-1:0][SEL_W-1:0]    mSel,
   output logic [NUM_MASTERS-1:0]               mAck,
   output logic [NUM_MASTERS-1:0]               mErr,
   output logic [DAT_W-1:0]                     mDatR,
   output logic                                 sStb,
   output logic                                 sWe,
   output logic [ADR_W-1:0]                     sAdr,
   output logic [DAT_W-1:0]                     sDatW,
   output logic [SEL_W-1:0]                     sSel,
   input  logic                                 sAck,
   input  logic                                 sErr,
   input  logic [DAT_W-1:0]                     sDatR
   );

   localparam int IDX_W = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1;

   logic                   busy;      // A master owns the shared bus
   logic [IDX_W-1:0]       grantIdx;  // Owner of the bus while busy
   logic [IDX_W-1:0]       rrPtr;     // First master to look at next time
   logic [IDX_W-1:0]       nextIdx;
   logic                   anyReq;
   logic [NUM_MASTERS-1:0] req;

   assign req = mCyc & mStb;

   // Search from rrPtr upwards, wrapping. Walk the offsets downwards so
   // the smallest offset with a request is the last one written
   always_comb begin : rrSearch
      int cand;
      nextIdx = rrPtr;
      anyReq  = 1'b0;
      for (int i = NUM_MASTERS - 1; i >= 0; i--) begin
         cand = int'(rrPtr) + i;
         if (cand >= NUM_MASTERS)
            cand = cand - NUM_MASTERS;
         if (req[cand]) begin
            nextIdx = IDX_W'(cand);
            anyReq  = 1'b1;
         end
      end
   end

   always_ff @(posedge CLK_I) begin
      if (!rstN) begin
         busy     <= 1'b0;
         grantIdx <= '0;
         rrPtr    <= '0;
      end else if (!busy) begin
         if (anyReq) begin
            busy     <= 1'b1;
            grantIdx <= nextIdx;
            // Winner goes to the back of the queue
            rrPtr    <= (nextIdx == IDX_W'(NUM_MASTERS - 1)) ? '0 : nextIdx + 1'b1;
         end
      end else if (sAck || sErr || !mCyc[grantIdx]) begin
         busy <= 1'b0;  // Response seen, or owner abandoned its cycle
      end
   end

   // Granted master's request onto the shared bus
   assign sStb  = busy & mCyc[grantIdx] & mStb[grantIdx];
   assign sWe   = mWe[grantIdx];
   assign sAdr  = mAdr[grantIdx];
   assign sDatW = mDatW[grantIdx];
   assign sSel  = mSel[grantIdx];

   // Response only to the owner
   always_comb begin
      mAck = '0;
      mErr = '0;
      if (busy) begin
         mAck[grantIdx] = sAck;
         mErr[grantIdx] = sErr;
      end
   end

   assign mDatR = sDatR;  // Shared, qualified by mAck

endmodule

`default_nettype wire

// ==== wbBus_asserts.sv ====
/*
 * Protocol checks bound into every wbArbiter instance.
 * Assumes masters hold their request until ack or err.
 * Checks are idle while rstN is low.
 */
`timescale 1ns/10ps
`default_nettype none

module wbBusAsserts
   import wbSimPkg::*;
   #(parameter int NUM_MASTERS = 2)
   (
   input logic                   CLK_I,
   input logic                   rstN,
   input logic [NUM_MASTERS-1:0] mAck,
   input logic [NUM_MASTERS-1:0] mErr,
   input logic                   sStb,
   input logic                   sWe,
   input logic [ADR_W-1:0]       sAdr,
   input logic                   sAck,
   input logic                   sErr
   );

   // Only one master answered per cycle
   oneResponse: assert property (@(posedge CLK_I) disable iff (!rstN)
      $onehot0({mAck, mErr}))
      else $error("More than one master response in one cycle");

   // Shared request held until the slave answers
   stbHeld: assert property (@(posedge CLK_I) disable iff (!rstN)
      sStb && !(sAck || sErr) |=> sStb && $stable(sAdr) && $stable(sWe))
      else $error("Shared strobe or request changed before a response");

   ackNotErr: assert property (@(posedge CLK_I) disable iff (!rstN) !(sAck && sErr))
      else $error("Slave ack and err high together");

endmodule

bind wbArbiter wbBusAsserts #(.NUM_MASTERS(NUM_MASTERS)) busChk (
   .CLK_I(CLK_I), .rstN(rstN), .mAck(mAck), .mErr(mErr), .sStb(sStb),
   .sWe(sWe), .sAdr(sAdr), .sAck(sAck), .sErr(sErr)
);

`default_nettype wire

// ==== wbCfgReg.sv ====
/*
 * Byte-writable configuration register, fixed one-cycle ack.
 * Bits 5..0 hold the write latency and bits 13..8 the read latency
 * of the latency register. Other bits are plain storage.
 * Both fields reset to RESET_LAT, all other bits to zero.
 */
`timescale 1ns/10ps
`default_nettype none

module wbCfgReg
   import wbSimPkg::*;
   #(parameter int RESET_LAT = 1)
   (
   input  logic             CLK_I,
   input  logic             rstN,
   input  logic             stb,
   input  logic             we,
   input  logic [SEL_W-1:0] sel,
   input  logic [DAT_W-1:0] datW,
   output logic             ack,
   output logic [DAT_W-1:0] datR,
   output logic [LAT_W-1:0] writeLat,
   output logic [LAT_W-1:0] readLat
   );

   localparam logic [DAT_W-1:0] RESET_VAL =
      (DAT_W'(RESET_LAT) << WLAT_LSB) | (DAT_W'(RESET_LAT) << RLAT_LSB);

   logic [DAT_W-1:0] cfgQ;
   logic             ackQ;

   always_ff @(posedge CLK_I) begin
      if (!rstN) begin
         cfgQ <= RESET_VAL;
         ackQ <= 1'b0;
      end else begin
         ackQ <= stb & ~ackQ;               // One pulse per access
         if (stb && we && !ackQ) begin      // First strobe cycle only
            for (int b = 0; b < SEL_W; b++)
               if (sel[b])
                  cfgQ[b*BYTE_W +: BYTE_W] <= datW[b*BYTE_W +: BYTE_W];
         end
      end
   end

   assign ack      = ackQ;
   assign datR     = cfgQ;  // Written value visible by the ack cycle
   assign writeLat = cfgQ[WLAT_LSB +: LAT_W];
   assign readLat  = cfgQ[RLAT_LSB +: LAT_W];

endmodule

`default_nettype wire

// ==== wbLatencyReg.sv ====
/*
 * Byte-writable data register with a programmable ack delay.
 * Ack comes writeLat cycles (write) or readLat cycles (read) after the strobe,
 * where a latency of 0 behaves as 1. Latency is sampled when the strobe starts.
 * Writes land on the ack edge. Dropping the strobe early aborts the access.
 */
`timescale 1ns/10ps
`default_nettype none

module wbLatencyReg
   import wbSimPkg::*;
   (
   input  logic             CLK_I,
   input  logic             rstN,
   input  logic             stb,
   input  logic             we,
   input  logic [SEL_W-1:0] sel,
   input  logic [DAT_W-1:0] datW,
   input  logic [LAT_W-1:0] writeLat,
   input  logic [LAT_W-1:0] readLat,
   output logic             ack,
   output logic [DAT_W-1:0] datR
   );

   logic [DAT_W-1:0] dataQ;
   logic [LAT_W-1:0] cnt;      // Cycles left until ack
   logic             active;   // Counting down
   logic             ackQ;
   logic             start;
   logic [LAT_W-1:0] effLat;

   // New access seen this cycle
   assign start = stb & ~active & ~ackQ;

   always_comb begin
      effLat = we ? writeLat : readLat;
      if (effLat == '0)
         effLat = LAT_W'(1);  // Zero still takes one cycle
   end

   always_ff @(posedge CLK_I) begin
      if (!rstN) begin
         active <= 1'b0;
         cnt    <= '0;
         ackQ   <= 1'b0;
      end else begin
         ackQ <= 1'b0;
         if (!stb) begin
            active <= 1'b0;                    // Master went away
         end else if (start) begin
            if (effLat == LAT_W'(1)) begin
               ackQ <= 1'b1;
            end else begin
               active <= 1'b1;
               cnt    <= effLat - LAT_W'(1);   // First cycle already spent
            end
         end else if (active) begin
            if (cnt == LAT_W'(1)) begin
               ackQ   <= 1'b1;
               active <= 1'b0;
            end else begin
               cnt <= cnt - LAT_W'(1);
            end
         end
      end
   end

   // Data update on the ack edge
   always_ff @(posedge CLK_I) begin
      if (!rstN) begin
         dataQ <= '0;
      end else if (stb && we && ackQ) begin
         for (int b = 0; b < SEL_W; b++)
            if (sel[b])
               dataQ[b*BYTE_W +: BYTE_W] <= datW[b*BYTE_W +: BYTE_W];
      end
   end

   assign ack  = ackQ;
   assign datR = dataQ;  // Old value during a write ack

endmodule

`default_nettype wire

// ==== wbSimCases.txt ====
# master conc we address wdata sel expected_rdata expected_err (address, data, sel in hex)
# we 1 is a write, 0 a read; expected_rdata counts only for reads without error
0 0 0 60000004 00000000 f 00000101 0
1 0 0 60000010 00000000 f 00000000 0
0 0 1 60000010 a5a5a5a5 f 00000000 0
1 0 1 60000010 11223344 2 00000000 0
0 0 0 60000010 00000000 f a5a533a5 0
1 0 1 60000004 12340000 c 00000000 0
0 0 0 60000004 00000000 f 12340101 0
1 0 1 60000004 ffffff04 1 00000000 0
0 0 1 60000004 ffff06ff 2 00000000 0
1 0 1 60000010 0f0f0f0f f 00000000 0
0 0 0 60000010 00000000 f 0f0f0f0f 0
1 0 1 60000014 00000000 1 00000000 0
0 0 0 60000014 00000000 f 12340600 0
0 0 1 60000000 ffffffff f 00000000 1
1 0 1 70000010 ffffffff f 00000000 1
0 0 0 10000004 00000000 f 00000000 1
1 0 0 60000004 00000000 f 12340600 0
0 0 0 60000010 00000000 f 0f0f0f0f 0
1 0 1 60000004 00003f00 2 00000000 0
0 0 1 60000010 000000aa 1 00000000 0
1 0 0 60000010 00000000 f 0f0f0faa 0
# both masters at once
0 1 1 60000010 55667788 f 00000000 0
1 1 0 60000004 00000000 f 12343f00 0
0 1 0 60000010 00000000 f 55667788 0
1 1 1 60000004 ab000000 8 00000000 0
1 1 0 60000000 00000000 f 00000000 1
0 1 0 60000010 00000000 f 55667788 0
0 0 0 60000004 00000000 f ab343f00 0

// ==== wbSimPkg.sv ====
/*
 * Shared constants for the Wishbone peripheral subsystem.
 * Peripheral region is 0b01100xxx_... at the top of the address space.
 * Inside the region bit 2 picks the config register and bit 4 the latency register.
 * With both bits set the config register wins.
 * Latency fields are 6 bits, so at most 63 cycles per access.
 */
`default_nettype none

package wbSimPkg;

   // Bus widths
   localparam int ADR_W  = 32;
   localparam int DAT_W  = 32;
   localparam int SEL_W  = DAT_W / 8;   // One select bit per byte
   localparam int BYTE_W = 8;

   // Peripheral region, bits 31..27 must read 01100
   localparam logic [ADR_W-1:0] REGION_MASK = 32'hF800_0000;
   localparam logic [ADR_W-1:0] REGION_BASE = 32'h6000_0000;

   // Register select bits inside the region
   localparam int CFG_BIT = 2;
   localparam int LAT_BIT = 4;

   // Latency fields of the config register
   localparam int LAT_W    = 6;
   localparam int WLAT_LSB = 0;         // Write latency in bits 5..0
   localparam int RLAT_LSB = 8;         // Read latency in bits 13..8

endpackage

`default_nettype wire

// ==== wbSimTop.sv ====
/*
 * Wishbone peripheral subsystem top level.
 * NUM_MASTERS classic masters share one bus through a round-robin arbiter.
 * Response time is one arbitration cycle plus the slave latency.
 * RESET_LAT is the latency the config register starts with.
 */
`timescale 1ns/10ps
`default_nettype none

module wbSimTop
   import wbSimPkg::*;
   #(
   parameter int NUM_MASTERS = 2,
   parameter int RESET_LAT   = 1
   )
   (
   input  logic                                 CLK_I,
   input  logic                                 rstN,
   input  logic [NUM_MASTERS-1:0]               mCyc,
   input  logic [NUM_MASTERS-1:0]               mStb,
   input  logic [NUM_MASTERS-1:0]               mWe,
   input  logic [NUM_MASTERS-1:0][ADR_W-1:0]    mAdr,
   input  logic [NUM_MASTERS-1:0][DAT_W-1:0]    mDatW,
   input  logic [NUM_MASTERS-1:0][SEL_W-1:0]    mSel,
   output logic [NUM_MASTERS-1:0]               mAck,
   output logic [NUM_MASTERS-1:0]               mErr,
   output logic [DAT_W-1:0]                     mDatR
   );

   // Shared bus
   logic             sStb, sWe, sAck, sErr;
   logic [ADR_W-1:0] sAdr;
   logic [DAT_W-1:0] sDatW, sDatR;
   logic [SEL_W-1:0] sSel;

   // Slave side
   logic             cfgStb, cfgAck, latStb, latAck;
   logic [DAT_W-1:0] cfgDatR, latDatR;
   logic [LAT_W-1:0] writeLat, readLat;

   wbArbiter #(.NUM_MASTERS(NUM_MASTERS)) arbInst (
      .CLK_I(CLK_I),  .rstN(rstN),
      .mCyc(mCyc),    .mStb(mStb),   .mWe(mWe),
      .mAdr(mAdr),    .mDatW(mDatW), .mSel(mSel),
      .mAck(mAck),    .mErr(mErr),   .mDatR(mDatR),
      .sStb(sStb),    .sWe(sWe),     .sAdr(sAdr),
      .sDatW(sDatW),  .sSel(sSel),
      .sAck(sAck),    .sErr(sErr),   .sDatR(sDatR)
   );

   wbAddrDecode decInst (
      .CLK_I(CLK_I),     .rstN(rstN),
      .sStb(sStb),       .sAdr(sAdr),
      .cfgAck(cfgAck),   .latAck(latAck),
      .cfgDatR(cfgDatR), .latDatR(latDatR),
      .cfgStb(cfgStb),   .latStb(latStb),
      .sAck(sAck),       .sErr(sErr),       .sDatR(sDatR)
   );

   wbCfgReg #(.RESET_LAT(RESET_LAT)) cfgInst (
      .CLK_I(CLK_I),  .rstN(rstN),
      .stb(cfgStb),   .we(sWe),       .sel(sSel),   .datW(sDatW),
      .ack(cfgAck),   .datR(cfgDatR),
      .writeLat(writeLat), .readLat(readLat)       // Into the slow slave
   );

   wbLatencyReg latInst (
      .CLK_I(CLK_I),  .rstN(rstN),
      .stb(latStb),   .we(sWe),       .sel(sSel),   .datW(sDatW),
      .writeLat(writeLat), .readLat(readLat),
      .ack(latAck),   .datR(latDatR)
   );

endmodule

`default_nettype wire
